// ==== verilog/rv_wb_pkg.sv ====
package rv_wb_pkg;

    parameter int XLEN       = 64;
    parameter int REG_ADDR_W = 5;
    parameter int ADDR_W     = 32;        // widest AXI address, top may narrow it
    parameter int STRB_W     = XLEN / 8;

    // width code applied before writeback or store
    typedef enum logic [1:0] {
        full        = 2'd0,  // result unchanged
        word_signed = 2'd1,  // low 32, sign extended
        word_zero   = 2'd2,  // low 32, zero extended
        half_signed = 2'd3   // low 16, sign extended
    } ext_kind_e;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic                  is_store;
        logic                  reg_wen;
        logic [REG_ADDR_W-1:0] rd;
        logic                  use_mem;   // take the memory-stage result
        logic [XLEN-1:0]       ex_res;
        logic [XLEN-1:0]       mem_res;
        ext_kind_e             ext;
        logic [REG_ADDR_W-1:0] base_reg;
        logic [31:0]           offset;    // store offset, sign extended later
        logic [STRB_W-1:0]     wmask;
    } wb_req_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic            was_store;
        logic            store_err;
    } retire_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [2:0]        prot;
    } axil_aw_t;

    typedef struct packed {
        logic [XLEN-1:0]   data;
        logic [STRB_W-1:0] strb;
    } axil_w_t;

endpackage

// ==== verilog/result_extend.sv ====
`timescale 1ns/10ps

module result_extend (
    input  logic [63:0]          value,
    input  rv_wb_pkg::ext_kind_e ext,
    output logic [63:0]          result
);

    import rv_wb_pkg::*;

    logic [XLEN-1:0] word_sx;
    logic [XLEN-1:0] word_zx;
    logic [XLEN-1:0] half_sx;

    assign word_sx = {{(XLEN-32){value[31]}}, value[31:0]};  // addw, lw style
    assign word_zx = {{(XLEN-32){1'b0}}, value[31:0]};
    assign half_sx = {{(XLEN-16){value[15]}}, value[15:0]};  // lh style

    always_comb begin
        case (ext)
            full: begin
                result = value;
            end
            word_signed: begin
                result = word_sx;
            end
            word_zero: begin
                result = word_zx;
            end
            half_signed: begin
                result = half_sx;
            end
            default: begin
                result = value;
            end
        endcase
    end

endmodule

// ==== verilog/gpr_file.sv ====
`timescale 1ns/10ps

module gpr_file (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             wr_en,
    input  logic [rv_wb_pkg::REG_ADDR_W-1:0] wr_addr,
    input  logic [rv_wb_pkg::XLEN-1:0]       wr_data,
    input  logic [rv_wb_pkg::REG_ADDR_W-1:0] rd_addr_a,
    output logic [rv_wb_pkg::XLEN-1:0]       rd_data_a,
    input  logic [rv_wb_pkg::REG_ADDR_W-1:0] rd_addr_b,
    output logic [rv_wb_pkg::XLEN-1:0]       rd_data_b,
    input  logic [rv_wb_pkg::REG_ADDR_W-1:0] base_addr,
    output logic [rv_wb_pkg::XLEN-1:0]       base_data
);

    import rv_wb_pkg::*;

    localparam int NREGS = 1 << REG_ADDR_W;

    logic [XLEN-1:0] regs [NREGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin  // writes to x0 dropped
            regs[wr_addr] <= wr_data;
        end
    end

    // decode ports, x0 stays zero since it is never written
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

    // store base, no bypass from the write port
    assign base_data = regs[base_addr];

endmodule

// ==== verilog/store_axil_writer.sv ====
`timescale 1ns/10ps

module store_axil_writer #(
    parameter int ADDR_W = rv_wb_pkg::ADDR_W
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                st_valid,
    input  rv_wb_pkg::axil_aw_t st_aw,
    input  rv_wb_pkg::axil_w_t  st_w,
    output logic                st_done,
    output logic                st_err,
    output logic                awvalid,
    output rv_wb_pkg::axil_aw_t aw,
    input  logic                awready,
    output logic                wvalid,
    output rv_wb_pkg::axil_w_t  w,
    input  logic                wready,
    input  logic                bvalid,
    input  logic [1:0]          bresp,
    output logic                bready
);

    import rv_wb_pkg::*;

    typedef enum logic [1:0] {
        idle = 2'd0,
        send = 2'd1,
        resp = 2'd2,
        done = 2'd3
    } wr_state_e;

    wr_state_e state;
    logic      aw_done;   // address beat accepted
    logic      w_done;    // data beat accepted
    logic      aw_fin;
    logic      w_fin;
    logic      err_q;
    axil_aw_t  aw_in;
    axil_aw_t  aw_q;
    axil_w_t   w_q;

    // clip the address to the configured bus width
    always_comb begin
        aw_in = st_aw;
        aw_in.addr = '0;
        aw_in.addr[ADDR_W-1:0] = st_aw.addr[ADDR_W-1:0];
    end

    assign awvalid = (state == send) && !aw_done;
    assign wvalid  = (state == send) && !w_done;
    assign bready  = (state == resp);

    // either beat may finish first
    assign aw_fin = aw_done || (awvalid && awready);
    assign w_fin  = w_done || (wvalid && wready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= idle;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    aw_done <= 1'b0;
                    w_done  <= 1'b0;
                    if (st_valid) begin
                        state <= send;
                    end
                end
                send: begin
                    aw_done <= aw_fin;
                    w_done  <= w_fin;
                    if (aw_fin && w_fin) begin
                        state <= resp;
                    end
                end
                resp: begin
                    if (bvalid) begin
                        err_q <= (bresp != 2'b00);  // slverr or decerr
                        state <= done;
                    end
                end
                default: begin
                    state <= idle;  // done lasts one cycle
                end
            endcase
        end
    end

    // payload held for the whole transfer
    always_ff @(posedge clk) begin
        if (state == idle && st_valid) begin
            aw_q <= aw_in;
            w_q  <= st_w;
        end
    end

    assign aw      = aw_q;
    assign w       = w_q;
    assign st_done = (state == done);
    assign st_err  = err_q;

endmodule

// ==== verilog/wb_stage.sv ====
`timescale 1ns/10ps

module wb_stage #(
    parameter int ADDR_W = rv_wb_pkg::ADDR_W
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             in_valid,
    input  rv_wb_pkg::wb_req_t               in_req,
    output logic                             in_ready,
    output logic                             wr_en,
    output logic [rv_wb_pkg::REG_ADDR_W-1:0] wr_addr,
    output logic [rv_wb_pkg::XLEN-1:0]       wr_data,
    output logic [rv_wb_pkg::REG_ADDR_W-1:0] base_addr,
    input  logic [rv_wb_pkg::XLEN-1:0]       base_data,
    output logic                             st_valid,
    output rv_wb_pkg::axil_aw_t              st_aw,
    output rv_wb_pkg::axil_w_t               st_w,
    input  logic                             st_done,
    input  logic                             st_err,
    output logic                             retire_valid,
    output rv_wb_pkg::retire_t               retire
);

    import rv_wb_pkg::*;

    logic            accept;
    logic            store_busy;   // one store in flight at most
    logic [XLEN-1:0] sel_res;
    logic [XLEN-1:0] ext_res;
    logic [XLEN-1:0] store_sum;
    axil_aw_t        aw_next;
    logic            ret_valid_q;
    logic [XLEN-1:0] ret_pc_q;
    logic [XLEN-1:0] store_pc;

    assign in_ready = !store_busy;
    assign accept   = in_valid && in_ready;

    assign sel_res = in_req.use_mem ? in_req.mem_res : in_req.ex_res;

    result_extend u_ext (
        .value  (sel_res),
        .ext    (in_req.ext),
        .result (ext_res)
    );

    // x0 filtering is left to the register file
    assign wr_en   = accept && in_req.reg_wen && !in_req.is_store;
    assign wr_addr = in_req.rd;
    assign wr_data = ext_res;

    assign base_addr = in_req.base_reg;
    assign store_sum = base_data + {{(XLEN-32){in_req.offset[31]}}, in_req.offset};

    always_comb begin
        aw_next = '0;                                   // prot 000, plain data access
        aw_next.addr[ADDR_W-1:0] = store_sum[ADDR_W-1:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            store_busy  <= 1'b0;
            st_valid    <= 1'b0;
            ret_valid_q <= 1'b0;
        end else begin
            st_valid    <= accept && in_req.is_store;
            ret_valid_q <= accept && !in_req.is_store;
            if (accept && in_req.is_store) begin
                store_busy <= 1'b1;
            end else if (st_done) begin
                store_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ret_pc_q <= in_req.pc;
        end
        if (accept && in_req.is_store) begin
            store_pc <= in_req.pc;
            st_aw    <= aw_next;
            st_w     <= '{data: ext_res, strb: in_req.wmask};
        end
    end

    // store retires straight off the writer's done pulse
    assign retire_valid = ret_valid_q || st_done;

    always_comb begin
        if (st_done) begin
            retire = '{pc: store_pc, was_store: 1'b1, store_err: st_err};
        end else begin
            retire = '{pc: ret_pc_q, was_store: 1'b0, store_err: 1'b0};
        end
    end

endmodule

// ==== verilog/wb_top.sv ====
`timescale 1ns/10ps

module wb_top #(
    parameter int ADDR_W = rv_wb_pkg::ADDR_W
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             in_valid,
    input  rv_wb_pkg::wb_req_t               in_req,
    output logic                             in_ready,
    input  logic [rv_wb_pkg::REG_ADDR_W-1:0] rd_addr_a,
    output logic [rv_wb_pkg::XLEN-1:0]       rd_data_a,
    input  logic [rv_wb_pkg::REG_ADDR_W-1:0] rd_addr_b,
    output logic [rv_wb_pkg::XLEN-1:0]       rd_data_b,
    output logic                             retire_valid,
    output rv_wb_pkg::retire_t               retire,
    output logic                             awvalid,
    output rv_wb_pkg::axil_aw_t              aw,
    input  logic                             awready,
    output logic                             wvalid,
    output rv_wb_pkg::axil_w_t               w,
    input  logic                             wready,
    input  logic                             bvalid,
    input  logic [1:0]                       bresp,
    output logic                             bready
);

    import rv_wb_pkg::*;

    logic                  wr_en;
    logic [REG_ADDR_W-1:0] wr_addr;
    logic [XLEN-1:0]       wr_data;
    logic [REG_ADDR_W-1:0] base_addr;
    logic [XLEN-1:0]       base_data;
    logic                  st_valid;
    axil_aw_t              st_aw;
    axil_w_t               st_w;
    logic                  st_done;
    logic                  st_err;

    wb_stage #(
        .ADDR_W (ADDR_W)
    ) u_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_req       (in_req),
        .in_ready     (in_ready),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .base_addr    (base_addr),
        .base_data    (base_data),
        .st_valid     (st_valid),
        .st_aw        (st_aw),
        .st_w         (st_w),
        .st_done      (st_done),
        .st_err       (st_err),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    gpr_file u_gpr (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_addr_a (rd_addr_a),
        .rd_data_a (rd_data_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_b (rd_data_b),
        .base_addr (base_addr),
        .base_data (base_data)
    );

    store_axil_writer #(
        .ADDR_W (ADDR_W)
    ) u_axil_wr (
        .clk      (clk),
        .rst_n    (rst_n),
        .st_valid (st_valid),
        .st_aw    (st_aw),
        .st_w     (st_w),
        .st_done  (st_done),
        .st_err   (st_err),
        .awvalid  (awvalid),
        .aw       (aw),
        .awready  (awready),
        .wvalid   (wvalid),
        .w        (w),
        .wready   (wready),
        .bvalid   (bvalid),
        .bresp    (bresp),
        .bready   (bready)
    );

endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/10ps

module clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== bench/wb_properties.sv ====
`timescale 1ns/10ps

module wb_properties (
    input logic        clk,
    input logic        rst_n,
    input logic        in_valid,
    input logic        in_ready,
    input logic        req_is_store,
    input logic        retire_valid,
    input logic        retire_was_store,
    input logic        awvalid,
    input logic        awready,
    input logic        wvalid,
    input logic        wready,
    input logic [4:0]  rd_addr_a,
    input logic [63:0] rd_data_a
);

    logic store_open;  // store accepted, not yet retired

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            store_open <= 1'b0;
        end else if (in_valid && in_ready && req_is_store) begin
            store_open <= 1'b1;
        end else if (retire_valid && retire_was_store) begin
            store_open <= 1'b0;
        end
    end

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid) else $error("awvalid dropped before awready");
    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid) else $error("wvalid dropped before wready");
    stall: assert property (@(posedge clk) disable iff (!rst_n)
        store_open |-> !in_ready) else $error("in_ready high while a store is open");
    x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        rd_addr_a == 5'd0 |-> rd_data_a == 64'd0) else $error("x0 read nonzero");

endmodule

bind wb_top wb_properties u_props (
    .clk              (clk),
    .rst_n            (rst_n),
    .in_valid         (in_valid),
    .in_ready         (in_ready),
    .req_is_store     (in_req.is_store),
    .retire_valid     (retire_valid),
    .retire_was_store (retire.was_store),
    .awvalid          (awvalid),
    .awready          (awready),
    .wvalid           (wvalid),
    .wready           (wready),
    .rd_addr_a        (rd_addr_a),
    .rd_data_a        (rd_data_a)
);

// ==== bench/wb_tb.sv ====
`timescale 1ns/10ps

module wb_tb;

    import rv_wb_pkg::*;

    localparam int TIMEOUT = 200;

    logic clk;
    logic rst_n;
    logic in_valid = 1'b0;
    wb_req_t in_req = '0;
    logic in_ready;
    logic [4:0] rd_addr_a = '0;
    logic [4:0] rd_addr_b = '0;
    logic [63:0] rd_data_a;
    logic [63:0] rd_data_b;
    logic retire_valid;
    retire_t retire;
    logic awvalid;
    axil_aw_t aw;
    logic awready = 1'b0;
    logic wvalid;
    axil_w_t w;
    logic wready = 1'b0;
    logic bvalid = 1'b0;
    logic [1:0] bresp = 2'b00;
    logic bready;

    // slave settings and observations
    int aw_delay = 0;
    int w_delay = 0;
    int b_delay = 0;
    logic [1:0] bresp_cfg = 2'b00;
    int aw_wait = 0;
    int w_wait = 0;
    int b_wait = 0;
    int aw_count = 0;
    int w_count = 0;
    int b_count = 0;
    logic [31:0] aw_seen = '0;
    logic [63:0] w_data_seen = '0;
    logic [7:0] w_strb_seen = '0;
    logic [63:0] model [32];

    clock_gen u_clk (.clk(clk), .rst_n(rst_n));

    wb_top #(.ADDR_W(32)) dut (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_req(in_req),
        .in_ready(in_ready), .rd_addr_a(rd_addr_a), .rd_data_a(rd_data_a),
        .rd_addr_b(rd_addr_b), .rd_data_b(rd_data_b), .retire_valid(retire_valid),
        .retire(retire), .awvalid(awvalid), .aw(aw), .awready(awready),
        .wvalid(wvalid), .w(w), .wready(wready), .bvalid(bvalid),
        .bresp(bresp), .bready(bready)
    );

    // AXI4-Lite slave with programmable ready delays
    always @(posedge clk) begin
        if (rst_n) begin
            if (awvalid && awready) begin
                awready <= 1'b0;
                aw_wait <= 0;
                aw_seen <= aw.addr;
                aw_count <= aw_count + 1;
            end else if (awvalid) begin
                if (aw_wait >= aw_delay) awready <= 1'b1;
                else aw_wait <= aw_wait + 1;
            end
            if (wvalid && wready) begin
                wready <= 1'b0;
                w_wait <= 0;
                w_data_seen <= w.data;
                w_strb_seen <= w.strb;
                w_count <= w_count + 1;
            end else if (wvalid) begin
                if (w_wait >= w_delay) wready <= 1'b1;
                else w_wait <= w_wait + 1;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                b_wait <= 0;
                b_count <= b_count + 1;
            end else if (bready) begin
                if (b_wait >= b_delay) begin
                    bvalid <= 1'b1;
                    bresp <= bresp_cfg;
                end else begin
                    b_wait <= b_wait + 1;
                end
            end
        end
    end

    task automatic abort(input string why);
        $display("failure: %s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("error %s: got %h, expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "simulation stopped");
        end
    endtask

    // width code rules
    function automatic logic [63:0] extended(input logic [63:0] v, input logic [1:0] code);
        case (code)
            2'd1: return 64'($signed(v[31:0]));
            2'd2: return {32'h0, v[31:0]};
            2'd3: return 64'($signed(v[15:0]));
            default: return v;
        endcase
    endfunction

    function automatic wb_req_t make_req(input logic [63:0] pc, input logic [4:0] rd,
                                         input logic use_mem, input logic [1:0] code,
                                         input logic is_store);
        wb_req_t r;
        r = '0;
        r.pc = pc;
        r.rd = rd;
        r.reg_wen = 1'b1;
        r.use_mem = use_mem;
        r.ext = ext_kind_e'(code);
        r.is_store = is_store;
        r.ex_res = {$urandom, $urandom};
        r.mem_res = {$urandom, $urandom};
        return r;
    endfunction

    function automatic logic [63:0] chosen(input wb_req_t r);
        return extended(r.use_mem ? r.mem_res : r.ex_res, r.ext);
    endfunction

    // holds in_valid until the request is taken
    task automatic offer(input wb_req_t r);
        int n;
        @(posedge clk);
        in_req <= r;
        in_valid <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!in_ready) begin
            n++;
            if (n > TIMEOUT) abort("request never accepted");
            @(negedge clk);
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic write_reg(input wb_req_t r);
        offer(r);
        @(negedge clk);
        check("retire_valid", 64'(retire_valid), 64'd1);
        check("retire.pc", retire.pc, r.pc);
        check("retire.was_store", 64'(retire.was_store), 64'd0);
        if (r.rd != 5'd0) model[r.rd] = chosen(r);
    endtask

    task automatic read_check(input logic [4:0] addr, input bit port_b);
        @(posedge clk);
        if (port_b) rd_addr_b <= addr;
        else rd_addr_a <= addr;
        @(negedge clk);
        if (port_b) check("rd_data_b", rd_data_b, model[addr]);
        else check("rd_data_a", rd_data_a, model[addr]);
    endtask

    // one store; optionally a register write waits behind it
    task automatic store_and_check(input wb_req_t s, input logic exp_err,
                                   input bit with_wr, input wb_req_t wr);
        int n;
        int aw0;
        int w0;
        int b0;
        bit retired;
        logic [63:0] sum;
        aw0 = aw_count;
        w0 = w_count;
        b0 = b_count;
        sum = model[s.base_reg] + 64'($signed(s.offset));
        offer(s);
        if (with_wr) begin
            in_req <= wr;
            in_valid <= 1'b1;
        end
        n = 0;
        retired = 0;
        while (!retired) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) abort("store never retired");
            if (retire_valid) retired = 1;
            else check("in_ready", 64'(in_ready), 64'd0);
        end
        check("retire.pc", retire.pc, s.pc);
        check("retire.was_store", 64'(retire.was_store), 64'd1);
        check("retire.store_err", 64'(retire.store_err), 64'(exp_err));
        check("in_ready", 64'(in_ready), 64'd0);
        check("aw.addr", 64'(aw_seen), 64'(sum[31:0]));
        check("w.data", w_data_seen, chosen(s));
        check("w.strb", 64'(w_strb_seen), 64'(s.wmask));
        check("aw_count", 64'(aw_count - aw0), 64'd1);
        check("w_count", 64'(w_count - w0), 64'd1);
        check("b_count", 64'(b_count - b0), 64'd1);
        if (with_wr) begin
            n = 0;
            @(negedge clk);
            while (!in_ready) begin
                n++;
                if (n > TIMEOUT) abort("in_ready stuck low after store");
                @(negedge clk);
            end
            @(posedge clk);
            in_valid <= 1'b0;
            @(negedge clk);
            check("retire_valid", 64'(retire_valid), 64'd1);
            check("retire.pc", retire.pc, wr.pc);
            model[wr.rd] = chosen(wr);
            read_check(wr.rd, 1'b0);
        end
    endtask

    task automatic run_store(input logic [31:0] offset, input int ad, input int wd,
                             input int bd, input logic [1:0] resp, input bit with_wr);
        wb_req_t s;
        wb_req_t wr;
        s = make_req(64'h2000 + 64'(b_count * 4), 5'd20, 1'b1, 2'd1, 1'b1);
        s.base_reg = 5'd5;
        s.offset = offset;
        s.wmask = 8'($urandom);
        wr = make_req(64'h2800 + 64'(b_count * 4), 5'd21, 1'b0, 2'd0, 1'b0);
        aw_delay = ad;
        w_delay = wd;
        b_delay = bd;
        bresp_cfg = resp;
        store_and_check(s, resp != 2'b00, with_wr, wr);
        read_check(5'd20, 1'b1);  // store leaves the register file alone
    endtask

    initial begin
        int n;
        wb_req_t r;
        for (int i = 0; i < 32; i++) model[i] = '0;
        void'($urandom(32'h607c_8332));
        n = 0;
        while (!rst_n) begin
            n++;
            if (n > TIMEOUT) abort("reset never released");
            @(posedge clk);
        end
        for (int i = 0; i < 8; i++) begin
            write_reg(make_req(64'h1000 + 64'(i * 4), 5'(i + 1), 1'(i % 2), 2'(i / 2), 1'b0));
        end
        for (int i = 1; i < 9; i++) read_check(5'(i), 1'(i % 2));
        write_reg(make_req(64'h1100, 5'd0, 1'b0, 2'd0, 1'b0));
        write_reg(make_req(64'h1104, 5'd1, 1'b1, 2'd0, 1'b0));
        read_check(5'd0, 1'b0);
        read_check(5'd1, 1'b1);
        write_reg(make_req(64'h1200, 5'd5, 1'b0, 2'd0, 1'b0));
        run_store(32'h0000_0120, 0, 0, 0, 2'b00, 0);
        run_store(32'hffff_ff00, 0, 0, 0, 2'b00, 0);
        run_store(32'h0000_0040, 4, 1, 3, 2'b00, 1);
        run_store(32'hffff_fff8, 1, 5, 6, 2'b00, 1);
        run_store(32'h0000_0010, 0, 2, 1, 2'b10, 0);
        for (int i = 1; i < 22; i++) read_check(5'(i), 1'b0);
        // back-to-back writes, in_valid held high
        @(posedge clk);
        for (int i = 0; i < 6; i++) begin
            r = make_req(64'h3000 + 64'(i * 4), 5'(10 + i), 1'(i % 2), 2'(i % 4), 1'b0);
            in_req <= r;
            in_valid <= 1'b1;
            model[10 + i] = chosen(r);
            @(negedge clk);
            check("in_ready", 64'(in_ready), 64'd1);
            if (i > 0) begin
                check("retire_valid", 64'(retire_valid), 64'd1);
                check("retire.pc", retire.pc, 64'h3000 + 64'((i - 1) * 4));
            end
            @(posedge clk);
        end
        in_valid <= 1'b0;
        @(negedge clk);
        check("retire_valid", 64'(retire_valid), 64'd1);
        check("retire.pc", retire.pc, 64'h3014);
        for (int i = 10; i < 16; i++) read_check(5'(i), 1'(i % 2));
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== files.f ====
verilog/rv_wb_pkg.sv
verilog/result_extend.sv
verilog/gpr_file.sv
verilog/store_axil_writer.sv
verilog/wb_stage.sv
verilog/wb_top.sv
bench/clock_gen.sv
bench/wb_properties.sv
bench/wb_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the writeback testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module wb_tb \
    --Mdir obj_dir -o wb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/wb_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q '^TEST OK$' sim.log; then
    exit 0
else
    echo "pass message not found in sim.log"
    exit 1
fi
